/* flist.f */
+incdir+verilog
verilog/sdr_link_pkg.sv
verilog/link_credit_fifo.sv
verilog/pod_config_regs.sv
verilog/sdr_link_endpoint.sv
verilog/xcel_bay.sv
verilog/sdr_pod_top.sv
testbench/sdr_pod_assertions.sv
testbench/sdr_pod_tb.sv

/* testbench/sdr_pod_assertions.sv */
`include "sdr_link_macros.svh"

module sdr_pod_assertions (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic [`SDR_NUM_LINKS-1:0] core_reset_i,
  input logic [`SDR_NUM_LINKS-1:0] fwd_token_i,
  input logic [`SDR_NUM_LINKS-1:0] rev_v_i,
  input logic [`SDR_NUM_LINKS-1:0] rev_token_i,
  input logic [`SDR_NUM_LINKS-1:0] req_v_i,
  input logic [`SDR_NUM_LINKS-1:0] resp_v_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // raised by any failing rule below
  logic assert_fail = 1'b0;

  for (genvar k = 0; k < `SDR_NUM_LINKS; k++) begin : g_link

    // responses sent and not yet paid back with a token
    logic [4:0] unpaid_q;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        unpaid_q <= '0;
      end else begin
        unpaid_q <= unpaid_q + 5'(rev_v_i[k]) - 5'(rev_token_i[k]);
      end
    end

    // second cycle of link reset onward, fifo state is defined
    assert property (@(posedge clk_i) core_reset_i[k] ##1 core_reset_i[k] |-> !fwd_token_i[k])
      else begin
        $error("forward token on link %0d while the link is in reset", k);
        assert_fail = 1'b1;
      end

    assert property (@(posedge clk_i) disable iff (rst_i) unpaid_q <= 5'(`SDR_FIFO_DEPTH))
      else begin
        $error("link %0d sent more responses than it held credits", k);
        assert_fail = 1'b1;
      end

    assert property (@(posedge clk_i) disable iff (rst_i) req_v_i[k] |=> resp_v_i[k])
      else begin
        $error("bay request on link %0d not answered one cycle later", k);
        assert_fail = 1'b1;
      end

  end

endmodule

/* testbench/sdr_pod_golden.txt */
# kind link op addr data exp_data exp_y; link and op decimal, the rest hex
# op 1 writes, 0 reads; burst reads data times; release checks credits held
req 0 1 5 a0a0a001 0 0
req 1 1 5 b1b1b102 0 1
req 2 1 5 c2c2c203 0 2
req 3 1 5 d3d3d304 0 3
req 0 0 5 0 a0a0a001 0
req 1 0 5 0 b1b1b102 1
req 2 0 5 0 c2c2c203 2
req 3 0 5 0 d3d3d304 3
req 2 0 9 0 0 2
# new pod x and base y
cfg 0 0 0 7 none none
cfg 0 0 1 10 none none
req 0 0 5 0 a0a0a001 10
req 1 0 5 0 b1b1b102 11
req 2 0 5 0 c2c2c203 12
req 3 0 5 0 d3d3d304 13
# link 2 masked off
cfg 0 0 2 b none none
req 2 1 5 deadbeef none none
req 2 0 5 0 none none
req 1 1 6 12345678 0 11
cfg 0 0 2 f none none
req 2 0 5 0 c2c2c203 12
req 1 0 6 0 12345678 11
# reverse tokens withheld on link 1
stall 1 0 0 0 none none
burst 1 0 5 14 b1b1b102 11
release 1 0 0 4 none none
# reset clears memories and coordinates
reset 0 0 0 0 none none
burst 3 0 5 8 0 3
req 0 0 5 0 0 0

/* testbench/sdr_pod_tb.sv */
`include "sdr_link_macros.svh"

module sdr_pod_tb
  import sdr_link_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int      N       = `SDR_NUM_LINKS;
  localparam int      CREDITS = `SDR_FIFO_DEPTH;
  localparam x_cord_t REQ_X   = 6'd21;

  // one line of the golden file
  typedef struct {
    string     kind;
    int        link;
    int        op;
    int        addr;
    sdr_data_t data;
    bit        has_exp;
    sdr_data_t exp_data;
    y_cord_t   exp_y;
  } step_t;

  logic             clk_i;
  logic             rst_i;
  logic             cfg_we_i;
  logic     [1:0]   cfg_addr_i;
  sdr_data_t        cfg_wdata_i;
  logic     [N-1:0] fwd_v_i;
  fwd_pkt_t [N-1:0] fwd_data_i;
  logic     [N-1:0] fwd_token_o;
  logic     [N-1:0] rev_v_o;
  rev_pkt_t [N-1:0] rev_data_o;
  logic     [N-1:0] rev_token_i;

  step_t    steps[$];
  rev_pkt_t exp_q[N][$];
  int       sent[N];
  int       tokens_back[N];
  int       owed[N];
  logic     [N-1:0] stall;
  x_cord_t  cur_pod_x;
  int       cycles;
  int       limit;
  int       seed;

  sdr_pod_top sdr_pod_top_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .fwd_v_i     (fwd_v_i),
    .fwd_data_i  (fwd_data_i),
    .fwd_token_o (fwd_token_o),
    .rev_v_o     (rev_v_o),
    .rev_data_o  (rev_data_o),
    .rev_token_i (rev_token_i)
  );

  bind sdr_pod_top sdr_pod_assertions sdr_pod_checks_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_reset_i (core_reset_lo),
    .fwd_token_i  (fwd_token_o),
    .rev_v_i      (rev_v_o),
    .rev_token_i  (rev_token_i),
    .req_v_i      (req_v),
    .resp_v_i     (resp_v)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_response(input int k);
    rev_pkt_t want;
    assert (exp_q[k].size() > 0)
      else stop_run($sformatf("[ERROR] %0d ns: response on link %0d, none expected", $time, k));
    want = exp_q[k].pop_front();
    assert (rev_data_o[k] == want)
      else stop_run($sformatf(
        "[ERROR] %0d ns: link %0d got %h x %0d y %0d tag %0d, want %h x %0d y %0d tag %0d",
        $time, k, rev_data_o[k].data, rev_data_o[k].src_x, rev_data_o[k].src_y,
        rev_data_o[k].dst_x, want.data, want.src_x, want.src_y, want.dst_x));
  endtask

  // ------------------------------------------------------------------------
  // mesh side model, credits and response checks
  // ------------------------------------------------------------------------

  always @(posedge clk_i) begin
    cycles++;
    assert (cycles < limit)
      else stop_run("timeout: the run did not finish within its cycle limit");
    assert (!sdr_pod_top_i.sdr_pod_checks_i.assert_fail)
      else stop_run("a bound protocol assertion failed");
    for (int k = 0; k < N; k++) begin
      if (fwd_token_o[k] === 1'b1) begin
        tokens_back[k] <= tokens_back[k] + 1;
      end
      if (rev_v_o[k] === 1'b1) begin
        check_response(k);
        owed[k]++;
      end
      // one reverse credit back per cycle unless held
      rev_token_i[k] <= !stall[k] && owed[k] > 0;
      if (!stall[k] && owed[k] > 0) begin
        owed[k]--;
      end
    end
  end

  function automatic bit link_busy();
    for (int k = 0; k < N; k++) begin
      if (exp_q[k].size() != 0 || sent[k] != tokens_back[k] || owed[k] != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic wait_idle();
    @(posedge clk_i);
    while (link_busy()) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
  endtask

  task automatic apply_reset();
    rst_i <= 1'b1;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    cur_pod_x = '0;
    // link k leaves reset k+1 cycles after rst_i
    repeat (N + 2) @(posedge clk_i);
  endtask

  task automatic write_config(input int addr, input sdr_data_t data);
    wait_idle();
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr[1:0];
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
    if (addr == 0) begin
      cur_pod_x = data[`SDR_X_W-1:0];
    end
    // base y ripples down the chain one link per cycle
    repeat (N + 2) @(posedge clk_i);
  endtask

  task automatic send_request(input step_t s);
    fwd_pkt_t pkt;
    rev_pkt_t want;
    pkt.op    = sdr_op_e'(s.op);
    pkt.addr  = sdr_addr_t'(s.addr);
    pkt.data  = s.data;
    // requester x doubles as a sequence tag so reordering shows up
    pkt.src_x = REQ_X + x_cord_t'(sent[s.link]);
    pkt.src_y = y_cord_t'(30 + s.link);
    @(posedge clk_i);
    while (sent[s.link] - tokens_back[s.link] >= CREDITS) begin
      @(posedge clk_i);
    end
    fwd_v_i[s.link]    <= 1'b1;
    fwd_data_i[s.link] <= pkt;
    sent[s.link]++;
    if (s.has_exp) begin
      want.data  = s.exp_data;
      want.dst_x = pkt.src_x;
      want.dst_y = pkt.src_y;
      want.src_x = cur_pod_x;
      want.src_y = s.exp_y;
      exp_q[s.link].push_back(want);
    end
    @(posedge clk_i);
    fwd_v_i[s.link] <= 1'b0;
  endtask

  task automatic run_step(input step_t s);
    step_t one;
    int    gap;
    int    held;
    one      = s;
    one.data = '0;
    case (s.kind)
      "cfg": write_config(s.addr, s.data);
      "req": begin
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk_i);
        send_request(s);
      end
      "burst": repeat (s.data) send_request(one);
      "stall": begin
        wait_idle();
        stall[s.link] <= 1'b1;
      end
      "release": begin
        repeat (30) @(posedge clk_i);
        held = CREDITS - (sent[s.link] - tokens_back[s.link]);
        assert (held == int'(s.data))
          else stop_run($sformatf("[ERROR] %0d ns: link %0d holds %0d credits, want %0d",
            $time, s.link, held, s.data));
        stall[s.link] <= 1'b0;
      end
      "reset": begin
        wait_idle();
        apply_reset();
      end
      default: stop_run($sformatf("golden file has an unknown step kind %s", s.kind));
    endcase
  endtask

  task automatic load_golden();
    int    fd;
    int    n;
    string line;
    string exp_d;
    string exp_y;
    step_t s;
    fd = $fopen("testbench/sdr_pod_golden.txt", "r");
    assert (fd != 0)
      else stop_run("could not open the golden file testbench/sdr_pod_golden.txt");
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s %d %d %h %h %s %s", s.kind, s.link, s.op, s.addr, s.data,
        exp_d, exp_y);
      if (n > 0 && line.substr(0, 0) != "#") begin
        assert (n == 7)
          else stop_run($sformatf("golden file line is malformed: %s", line));
        s.has_exp = (exp_d != "none");
        if (s.has_exp) begin
          void'($sscanf(exp_d, "%h", s.exp_data));
          void'($sscanf(exp_y, "%h", s.exp_y));
        end
        steps.push_back(s);
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    fwd_v_i     = '0;
    fwd_data_i  = '0;
    rev_token_i = '0;
    stall       = '0;
    cur_pod_x   = '0;
    cycles      = 0;
    seed        = 72611;
    limit       = 200;
    for (int k = 0; k < N; k++) begin
      sent[k]        = 0;
      tokens_back[k] = 0;
      owed[k]        = 0;
    end
    load_golden();
    limit = 40 * steps.size() + 200;
    apply_reset();
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    wait_idle();
    if (!sdr_pod_top_i.sdr_pod_checks_i.assert_fail) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* verilog/link_credit_fifo.sv */
`include "sdr_link_macros.svh"

module link_credit_fifo
  import sdr_link_pkg::*;
#(
  parameter type payload_t = fwd_pkt_t
) (
  input  logic                        clk_i,
  input  logic                        rst_i,

  input  logic                        push_i,
  input  payload_t                    data_i,

  input  logic                        pop_i,
  output payload_t                    data_o,
  output logic                        valid_o,

  output logic [`SDR_LG_FIFO_DEPTH:0] free_o,
  output logic                        token_o
);

  localparam int PTR_W = `SDR_LG_FIFO_DEPTH;
  localparam int CNT_W = `SDR_LG_FIFO_DEPTH + 1;
  localparam int DEPTH = `SDR_FIFO_DEPTH;

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // head of queue is read straight from storage
  assign data_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign free_o  = CNT_W'(DEPTH) - count_q;

  assign do_pop  = pop_i && valid_o;
  // a full buffer still takes a push in the cycle it pops
  assign do_push = push_i && ((count_q != CNT_W'(DEPTH)) || do_pop);

  // one credit back per popped entry
  assign token_o = do_pop;

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // ------------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // pointers wrap naturally at the power-of-two depth
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

/* verilog/pod_config_regs.sv */
`include "sdr_link_macros.svh"

module pod_config_regs
  import sdr_link_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,

  // register write port
  input  logic                      cfg_we_i,
  input  logic [1:0]                cfg_addr_i,
  input  sdr_data_t                 cfg_wdata_i,

  output x_cord_t                   pod_x_o,
  output y_cord_t                   base_y_o,
  output logic [`SDR_NUM_LINKS-1:0] link_en_o
);

  // register map
  localparam logic [1:0] CFG_POD_X   = 2'd0;
  localparam logic [1:0] CFG_BASE_Y  = 2'd1;
  localparam logic [1:0] CFG_LINK_EN = 2'd2;

  x_cord_t                   pod_x_q;
  y_cord_t                   base_y_q;
  logic [`SDR_NUM_LINKS-1:0] link_en_q;

  // ------------------------------------------------------------------------
  // register file
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pod_x_q   <= '0;
      base_y_q  <= '0;
      // all links come up enabled
      link_en_q <= '1;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_POD_X: begin
          pod_x_q <= cfg_wdata_i[`SDR_X_W-1:0];
        end
        CFG_BASE_Y: begin
          base_y_q <= cfg_wdata_i[`SDR_Y_W-1:0];
        end
        CFG_LINK_EN: begin
          link_en_q <= cfg_wdata_i[`SDR_NUM_LINKS-1:0];
        end
        default: begin
          // address 3 is reserved, write dropped
        end
      endcase
    end
  end

  assign pod_x_o   = pod_x_q;
  assign base_y_o  = base_y_q;
  assign link_en_o = link_en_q;

endmodule

/* verilog/sdr_link_endpoint.sv */
`include "sdr_link_macros.svh"

module sdr_link_endpoint
  import sdr_link_pkg::*;
(
  input  logic     clk_i,

  // reset chain
  input  logic     core_reset_i,
  output logic     core_reset_o,

  // coordinate chain
  input  x_cord_t  core_x_i,
  input  y_cord_t  core_y_i,
  output y_cord_t  core_y_o,

  input  logic     link_en_i,

  // mesh side, forward requests in
  input  logic     fwd_v_i,
  input  fwd_pkt_t fwd_data_i,
  output logic     fwd_token_o,

  // mesh side, reverse responses out
  output logic     rev_v_o,
  output rev_pkt_t rev_data_o,
  input  logic     rev_token_i,

  // bay side
  output logic     req_v_o,
  output fwd_pkt_t req_pkt_o,
  input  logic     resp_v_i,
  input  rev_pkt_t resp_pkt_i
);

  localparam int CNT_W = `SDR_LG_FIFO_DEPTH + 1;

  logic             reset_q;
  y_cord_t          core_y_q;

  logic             fwd_valid;
  logic             fwd_pop;
  fwd_pkt_t         fwd_head;

  logic             rev_valid;
  logic             rev_send;
  logic             rev_pop_token;
  logic [CNT_W-1:0] rev_free;
  logic [CNT_W-1:0] rev_credit_q;

  // ------------------------------------------------------------------------
  // reset and coordinate chain
  // ------------------------------------------------------------------------

  // each hop adds one cycle, so link k leaves reset k+1 cycles late
  always_ff @(posedge clk_i) begin
    reset_q  <= core_reset_i;
    core_y_q <= core_y_i + y_cord_t'(1);
  end

  assign core_reset_o = reset_q;
  assign core_y_o     = core_y_q;

  // ------------------------------------------------------------------------
  // forward path
  // ------------------------------------------------------------------------

  link_credit_fifo #(
    .payload_t (fwd_pkt_t)
  ) fwd_fifo (
    .clk_i   (clk_i),
    .rst_i   (reset_q),
    .push_i  (fwd_v_i),
    .data_i  (fwd_data_i),
    .pop_i   (fwd_pop),
    .data_o  (fwd_head),
    .valid_o (fwd_valid),
    .free_o  (),
    .token_o (fwd_token_o)
  );

  // a response arriving this cycle already owns one of the free slots,
  // so an enabled pop needs one more slot beyond it.
  // disabled links drain without touching the reverse side
  assign fwd_pop = fwd_valid && (!link_en_i || (rev_free > CNT_W'(resp_v_i)));

  assign req_v_o   = fwd_pop && link_en_i;
  assign req_pkt_o = fwd_head;

  // ------------------------------------------------------------------------
  // reverse path
  // ------------------------------------------------------------------------

  link_credit_fifo #(
    .payload_t (rev_pkt_t)
  ) rev_fifo (
    .clk_i   (clk_i),
    .rst_i   (reset_q),
    .push_i  (resp_v_i),
    .data_i  (resp_pkt_i),
    .pop_i   (rev_send),
    .data_o  (rev_data_o),
    .valid_o (rev_valid),
    .free_o  (rev_free),
    .token_o (rev_pop_token)
  );

  // send whenever an entry and a mesh credit are both there
  assign rev_send = rev_valid && (rev_credit_q != '0);
  assign rev_v_o  = rev_send;

  // credits held toward the mesh
  always_ff @(posedge clk_i) begin
    if (reset_q) begin
      rev_credit_q <= CNT_W'(`SDR_FIFO_DEPTH);
    end else begin
      rev_credit_q <= rev_credit_q + CNT_W'(rev_token_i) - CNT_W'(rev_pop_token);
    end
  end

  // ------------------------------------------------------------------------
  // link coordinate check
  // ------------------------------------------------------------------------

  // outgoing responses carry this link's coordinate, a mismatch means the
  // bay was wired to the wrong chain position
  always_ff @(posedge clk_i) begin
    if (!reset_q && rev_send) begin
      assert ((rev_data_o.src_x == core_x_i) && (rev_data_o.src_y == core_y_i))
        else $error("response source does not match link coordinate");
    end
  end

endmodule

/* verilog/sdr_link_macros.svh */
`ifndef SDR_LINK_MACROS_SVH
`define SDR_LINK_MACROS_SVH

// ------------------------------------------------------------------------
// link geometry
// ------------------------------------------------------------------------

// side links between the mesh and the bay
`define SDR_NUM_LINKS 4

// per-direction buffering, also the initial credit count of each sender
`define SDR_LG_FIFO_DEPTH 3
`define SDR_FIFO_DEPTH (1 << `SDR_LG_FIFO_DEPTH)

// ------------------------------------------------------------------------
// packet field widths
// ------------------------------------------------------------------------

`define SDR_ADDR_W 4
`define SDR_DATA_W 32
`define SDR_X_W 6
`define SDR_Y_W 6

`endif

/* verilog/sdr_link_pkg.sv */
`include "sdr_link_macros.svh"

package sdr_link_pkg;

  // ------------------------------------------------------------------------
  // field types
  // ------------------------------------------------------------------------

  typedef logic [`SDR_ADDR_W-1:0] sdr_addr_t;
  typedef logic [`SDR_DATA_W-1:0] sdr_data_t;
  typedef logic [`SDR_X_W-1:0]    x_cord_t;
  typedef logic [`SDR_Y_W-1:0]    y_cord_t;

  // request opcode
  typedef enum logic {
    SDR_OP_READ  = 1'b0,
    SDR_OP_WRITE = 1'b1
  } sdr_op_e;

  // ------------------------------------------------------------------------
  // packets
  // ------------------------------------------------------------------------

  // forward request, mesh into bay
  typedef struct packed {
    sdr_op_e   op;
    sdr_addr_t addr;
    sdr_data_t data;
    x_cord_t   src_x;
    y_cord_t   src_y;
  } fwd_pkt_t;

  // reverse response, bay back to mesh
  // dst is the requester, src is the answering link
  typedef struct packed {
    sdr_data_t data;
    x_cord_t   dst_x;
    y_cord_t   dst_y;
    x_cord_t   src_x;
    y_cord_t   src_y;
  } rev_pkt_t;

endpackage

/* verilog/sdr_pod_top.sv */
`include "sdr_link_macros.svh"

module sdr_pod_top
  import sdr_link_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,

  // configuration write port
  input  logic                          cfg_we_i,
  input  logic     [1:0]                cfg_addr_i,
  input  sdr_data_t                     cfg_wdata_i,

  // mesh side links
  input  logic     [`SDR_NUM_LINKS-1:0] fwd_v_i,
  input  fwd_pkt_t [`SDR_NUM_LINKS-1:0] fwd_data_i,
  output logic     [`SDR_NUM_LINKS-1:0] fwd_token_o,

  output logic     [`SDR_NUM_LINKS-1:0] rev_v_o,
  output rev_pkt_t [`SDR_NUM_LINKS-1:0] rev_data_o,
  input  logic     [`SDR_NUM_LINKS-1:0] rev_token_i
);

  localparam int N = `SDR_NUM_LINKS;

  x_cord_t          pod_x;
  y_cord_t          base_y;
  logic     [N-1:0] link_en;

  logic     [N-1:0] core_reset_li;
  logic     [N-1:0] core_reset_lo;
  y_cord_t  [N-1:0] core_y_li;
  y_cord_t  [N-1:0] core_y_lo;
  x_cord_t  [N-1:0] link_x;

  logic     [N-1:0] req_v;
  fwd_pkt_t [N-1:0] req_pkt;
  logic     [N-1:0] resp_v;
  rev_pkt_t [N-1:0] resp_pkt;

  pod_config_regs cfg_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .pod_x_o     (pod_x),
    .base_y_o    (base_y),
    .link_en_o   (link_en)
  );

  // ------------------------------------------------------------------------
  // endpoint chain, link 0 at the head
  // ------------------------------------------------------------------------

  for (genvar k = 0; k < N; k++) begin : g_ep

    if (k == 0) begin : g_head
      assign core_reset_li[k] = rst_i;
      assign core_y_li[k]     = base_y;
    end else begin : g_chain
      assign core_reset_li[k] = core_reset_lo[k-1];
      assign core_y_li[k]     = core_y_lo[k-1];
    end

    // all links of the pod share one x
    assign link_x[k] = pod_x;

    sdr_link_endpoint ep (
      .clk_i        (clk_i),
      .core_reset_i (core_reset_li[k]),
      .core_reset_o (core_reset_lo[k]),
      .core_x_i     (link_x[k]),
      .core_y_i     (core_y_li[k]),
      .core_y_o     (core_y_lo[k]),
      .link_en_i    (link_en[k]),
      .fwd_v_i      (fwd_v_i[k]),
      .fwd_data_i   (fwd_data_i[k]),
      .fwd_token_o  (fwd_token_o[k]),
      .rev_v_o      (rev_v_o[k]),
      .rev_data_o   (rev_data_o[k]),
      .rev_token_i  (rev_token_i[k]),
      .req_v_o      (req_v[k]),
      .req_pkt_o    (req_pkt[k]),
      .resp_v_i     (resp_v[k]),
      .resp_pkt_i   (resp_pkt[k])
    );

  end

  xcel_bay bay (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_v_i    (req_v),
    .req_pkt_i  (req_pkt),
    .link_x_i   (link_x),
    .link_y_i   (core_y_li),
    .resp_v_o   (resp_v),
    .resp_pkt_o (resp_pkt)
  );

endmodule

/* verilog/xcel_bay.sv */
`include "sdr_link_macros.svh"

module xcel_bay
  import sdr_link_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,

  // requests from the endpoints
  input  logic     [`SDR_NUM_LINKS-1:0] req_v_i,
  input  fwd_pkt_t [`SDR_NUM_LINKS-1:0] req_pkt_i,

  // coordinate of each link, stamped on its responses
  input  x_cord_t  [`SDR_NUM_LINKS-1:0] link_x_i,
  input  y_cord_t  [`SDR_NUM_LINKS-1:0] link_y_i,

  // responses back to the endpoints
  output logic     [`SDR_NUM_LINKS-1:0] resp_v_o,
  output rev_pkt_t [`SDR_NUM_LINKS-1:0] resp_pkt_o
);

  localparam int SCRATCH_WORDS = 1 << `SDR_ADDR_W;

  for (genvar k = 0; k < `SDR_NUM_LINKS; k++) begin : g_link

    sdr_data_t mem_q [SCRATCH_WORDS];
    logic      resp_v_q;
    rev_pkt_t  resp_pkt_q;
    logic      is_write;

    assign is_write = (req_pkt_i[k].op == SDR_OP_WRITE);

    // ----------------------------------------------------------------------
    // scratch memory
    // ----------------------------------------------------------------------

    // cleared at reset so reads after reset return zero
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        for (int w = 0; w < SCRATCH_WORDS; w++) begin
          mem_q[w] <= '0;
        end
      end else if (req_v_i[k] && is_write) begin
        mem_q[req_pkt_i[k].addr] <= req_pkt_i[k].data;
      end
    end

    // ----------------------------------------------------------------------
    // response, one cycle after the request
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        resp_v_q <= 1'b0;
      end else begin
        resp_v_q <= req_v_i[k];
      end
    end

    always_ff @(posedge clk_i) begin
      if (req_v_i[k]) begin
        // writes answer zero
        resp_pkt_q.data  <= is_write ? '0 : mem_q[req_pkt_i[k].addr];
        resp_pkt_q.dst_x <= req_pkt_i[k].src_x;
        resp_pkt_q.dst_y <= req_pkt_i[k].src_y;
        resp_pkt_q.src_x <= link_x_i[k];
        resp_pkt_q.src_y <= link_y_i[k];
      end
    end

    assign resp_v_o[k]   = resp_v_q;
    assign resp_pkt_o[k] = resp_pkt_q;

  end

endmodule
